//--- rv_core.f
verilog/rv_core_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_csr_file.sv
verilog/rv_core_ctrl.sv
verilog/rv_core.sv
+incdir+tests
tests/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - verilog/rv_core_pkg.sv
      - verilog/rv_decoder.sv
      - verilog/rv_alu.sv
      - verilog/rv_regfile.sv
      - verilog/rv_csr_file.sv
      - verilog/rv_core_ctrl.sv
      - verilog/rv_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/rv_core_tb.sv

//--- tests/rv_core_ref.svh
`ifndef RV_CORE_REF_SVH
`define RV_CORE_REF_SVH

word_t     seed = 32'd92660;
word_t     ref_mem [0:MEM_WORDS-1];
word_t     m_x [0:31] = '{default: '0};
word_t     m_pc, m_mtvec, m_mepc, m_mcause, m_mscratch;
word_t     exp_pc, exp_data;
reg_addr_t exp_rd;
logic      exp_halt;
int        gen_len;

function automatic word_t next_random();
  seed = seed * 32'd1664525 + 32'd1013904223;
  return {seed[15:0], seed[31:16]};  // low lcg bits are weak
endfunction

function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'b0, $signed(a) < $signed(b)};
    3'd3: return {31'b0, a < b};
    3'd4: return a ^ b;
    3'd5: begin
      if (alt)
        return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

task automatic reset_model();
  m_pc = RESET_VECTOR;
  m_mtvec = '0;
  m_mepc = '0;
  m_mcause = '0;
  m_mscratch = '0;
endtask

// one instruction, gives expected pc, rd and value
task automatic step_model();
  word_t      ins, a, b, v, adr, immi, imms, immb, immj, immu;
  logic [2:0] f3;
  logic       wr;
  ins = ref_mem[m_pc[12:2]];
  f3 = ins[14:12];
  a = m_x[ins[19:15]];
  b = m_x[ins[24:20]];
  immi = {{20{ins[31]}}, ins[31:20]};
  imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  immu = {ins[31:12], 12'b0};
  exp_pc = m_pc;
  exp_halt = 1'b0;
  wr = 1'b1;
  v = '0;
  m_pc = m_pc + 32'd4;
  case (ins[6:0])
    7'h37: v = immu;
    7'h17: v = exp_pc + immu;
    7'h6f: begin
      v = m_pc;
      m_pc = exp_pc + immj;
    end
    7'h67: begin
      v = m_pc;
      m_pc = (a + immi) & ~32'd1;
    end
    7'h63: begin
      wr = 1'b0;
      if (branch_taken(f3, a, b))
        m_pc = exp_pc + immb;
    end
    7'h03: begin
      adr = a + immi;
      v = ref_mem[adr[12:2]];
    end
    7'h23: begin
      wr = 1'b0;
      adr = a + imms;
      ref_mem[adr[12:2]] = b;
    end
    7'h13: v = alu_model(f3, f3 == 3'd5 && ins[30], a, immi);
    7'h33: v = alu_model(f3, ins[30], a, b);
    7'h73: begin
      wr = 1'b0;
      if (ins == 32'h0000_0073) begin  // ecall
        m_mepc = exp_pc;
        m_mcause = 32'd11;
        m_pc = m_mtvec;
      end else if (ins == 32'h3020_0073) begin
        m_pc = m_mepc;
      end else if (f3 == 3'b001) begin  // csrrw, old value to rd
        wr = 1'b1;
        case (ins[31:20])
          12'h305: begin v = m_mtvec; m_mtvec = a; end
          12'h341: begin v = m_mepc; m_mepc = a; end
          12'h342: begin v = m_mcause; m_mcause = a; end
          12'h340: begin v = m_mscratch; m_mscratch = a; end
          default: v = '0;
        endcase
      end else begin
        exp_halt = 1'b1;  // ebreak
      end
    end
    default: exp_halt = 1'b1;
  endcase
  exp_rd = (wr && !exp_halt) ? ins[11:7] : '0;
  exp_data = (exp_rd != '0) ? v : '0;
  if (exp_rd != '0)
    m_x[exp_rd] = v;
endtask

task automatic put_word(word_t w);
  ref_mem[gen_len] = w;
  gen_len++;
endtask

task automatic add_alu_op();
  word_t      r, r2;
  logic [2:0] f3;
  logic [11:0] imm;
  r = next_random();
  r2 = next_random();
  f3 = r[2:0];
  if (f3 == 3'd1)
    imm = {7'b0, r[24:20]};
  else if (f3 == 3'd5)
    imm = {1'b0, r[18], 5'b0, r[24:20]};  // srli or srai
  else
    imm = r[31:20];
  case (r2[1:0])
    2'd0: put_word({(f3 == 3'd0 || f3 == 3'd5) && r[18] ? 7'h20 : 7'h00,
                    r[17:13], r[12:8], f3, r[7:3], 7'h33});
    2'd1: put_word({imm, r[12:8], f3, r[7:3], 7'h13});
    2'd2: put_word({r2[31:12], r[7:3], 7'h37});
    default: put_word({r2[31:12], r[7:3], 7'h17});
  endcase
endtask

// lui base into the data area, then lw or sw
task automatic add_mem_op();
  word_t      r;
  reg_addr_t  rb;
  logic [11:0] off;
  r = next_random();
  rb = (r[4:0] == '0) ? 5'd1 : r[4:0];
  off = {2'b0, r[17:10], 2'b0};
  put_word({20'h80001, rb, 7'h37});
  if (r[18])
    put_word({off, rb, 3'b010, r[9:5], 7'h03});
  else
    put_word({off[11:5], r[9:5], rb, 3'b010, off[4:0], 7'h23});
endtask

// forward only, skips k filler words
task automatic add_jump();
  word_t      r;
  reg_addr_t  rd, rt;
  logic [2:0] f3;
  logic [20:0] off;
  int         k;
  r = next_random();
  k = r[1:0];
  off = 21'(4 * (k + 1));
  rd = r[8:4];
  rt = (r[23:19] == '0) ? 5'd1 : r[23:19];
  f3 = r[26:24];
  if (f3[2:1] == 2'b01)
    f3[2] = 1'b1;  // no branch on funct3 2 or 3
  case (r[3:2])
    2'd2: put_word({off[20], off[10:1], off[11], off[19:12], rd, 7'h6f});
    2'd3: begin
      put_word({20'h0, rt, 7'h17});
      put_word({off[11:0] + 12'd4, rt, 3'b000, rd, 7'h67});
    end
    default: put_word({off[12], off[10:5], r[18:14], r[13:9], f3, off[4:1], off[11], 7'h63});
  endcase
  repeat (k) add_alu_op();
endtask

// mode 0 alu only, 1 adds lw/sw, 2 adds jumps
task automatic build_program(int mode, word_t last_word);
  word_t r;
  int    kind;
  for (int i = 0; i < MEM_WORDS; i++)
    ref_mem[i] = next_random();
  gen_len = 0;
  for (int i = 1; i < 32; i++) begin
    r = next_random();
    put_word({r[31:12], 5'(i), 7'h37});
  end
  repeat (60) begin
    kind = next_random() % 4;
    if (mode >= 1 && kind == 1)
      add_mem_op();
    else if (mode >= 2 && kind == 2)
      add_jump();
    else
      add_alu_op();
  end
  put_word(last_word);
endtask

task automatic build_trap_program();
  for (int i = 0; i < MEM_WORDS; i++)
    ref_mem[i] = next_random();
  gen_len = 0;
  put_word({20'h80000, 5'd5, 7'h37});
  put_word({12'h040, 5'd5, 3'b000, 5'd5, 7'h13});     // handler at word 16
  put_word({12'h305, 5'd5, 3'b001, 5'd0, 7'h73});     // mtvec
  put_word({12'h123, 5'd0, 3'b000, 5'd6, 7'h13});
  put_word({12'h340, 5'd6, 3'b001, 5'd7, 7'h73});     // mscratch
  put_word(32'h0000_0073);
  put_word({12'h340, 5'd0, 3'b001, 5'd11, 7'h73});
  put_word(32'h0010_0073);
  gen_len = 16;
  put_word({12'h341, 5'd0, 3'b001, 5'd9, 7'h73});     // read mepc
  put_word({12'h342, 5'd0, 3'b001, 5'd10, 7'h73});    // read mcause
  put_word({12'h004, 5'd9, 3'b000, 5'd12, 7'h13});
  put_word({12'h341, 5'd12, 3'b001, 5'd0, 7'h73});    // resume past ecall
  put_word(32'h3020_0073);
endtask

`endif

//--- tests/rv_core_tb.sv
module rv_core_tb import rv_core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 2048;
  localparam int NUM_PROGS = 13;
  localparam int TIMEOUT = 200;
  localparam int QUIET_CYCLES = 50;

  logic      clk = 1'b0;
  logic      reset = 1'b1;
  logic      wb_cyc, wb_stb, wb_we;
  word_t     wb_adr, wb_dat_w;
  word_t     wb_dat_r = '0;
  logic      wb_ack = 1'b0;
  logic      retire_valid, halted;
  word_t     retire_pc, retire_data;
  reg_addr_t retire_rd;

  word_t mem [0:MEM_WORDS-1];
  word_t dut_last [0:31];  // last retired value per register
  int    errors = 0;
  int    timeouts = 0;
  logic  busy = 1'b0;
  int    wait_left;

  `include "rv_core_ref.svh"

  rv_core UUT (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .retire_valid, .retire_pc, .retire_rd, .retire_data, .halted
  );

  always #5 clk = ~clk;

  // wishbone slave, 0 to 3 wait states
  always @(negedge clk) begin
    if (reset || wb_ack) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        wait_left = next_random() % 4;
      end
      if (wait_left == 0) begin
        wb_ack <= 1'b1;
        wb_dat_r <= mem[wb_adr[12:2]];
        if (wb_we)
          mem[wb_adr[12:2]] = wb_dat_w;
      end else begin
        wait_left--;
      end
    end
  end

  task automatic check_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(string what, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic run_program();
    int n;
    mem = ref_mem;
    reset_model();
    reset <= 1'b1;
    repeat (10) @(negedge clk);
    check_flag("wb_cyc in reset", wb_cyc, 1'b0);
    check_flag("wb_stb in reset", wb_stb, 1'b0);
    check_flag("wb_we in reset", wb_we, 1'b0);
    check_flag("retire_valid in reset", retire_valid, 1'b0);
    check_flag("halted in reset", halted, 1'b0);
    reset <= 1'b0;
    n = 0;
    while (!wb_cyc && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!wb_cyc) begin
      $display("Timeout: the core never started a fetch after reset");
      timeouts++;
      return;
    end
    check_word("first fetch address", wb_adr, RESET_VECTOR);
    do begin
      step_model();
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!retire_valid && !halted && n < TIMEOUT);
      if (!retire_valid && !halted) begin
        $display("Timeout: nothing retired for the instruction at pc %h", exp_pc);
        timeouts++;
        return;
      end
      if (exp_halt) begin
        check_flag("halted", halted, 1'b1);
        check_flag("retire_valid at halt", retire_valid, 1'b0);
      end else begin
        check_flag("halted", halted, 1'b0);
        check_word("retire_pc", retire_pc, exp_pc);
        check_reg("retire_rd", retire_rd, exp_rd);
        check_word("retire_data", retire_data, exp_data);
        dut_last[retire_rd] = retire_data;
      end
    end while (!exp_halt && !halted);
    // a halted core stays off the bus
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_flag("wb_cyc after halt", wb_cyc, 1'b0);
      check_flag("retire_valid after halt", retire_valid, 1'b0);
    end
    for (int i = 0; i < MEM_WORDS; i++)
      check_word("memory word", mem[i], ref_mem[i]);
  endtask

  initial begin
    for (int p = 0; p < NUM_PROGS && timeouts == 0; p++) begin
      if (p == 0)
        build_trap_program();
      else
        build_program((p - 1) % 3, (p % 2) ? 32'h0010_0073 : 32'hffff_ffff);
      run_program();
      if (p == 0 && timeouts == 0) begin
        check_word("mepc read", dut_last[9], 32'h8000_0014);
        check_word("mcause read", dut_last[10], MCAUSE_ECALL);
        check_word("mscratch after mret", dut_last[11], 32'h0000_0123);
      end
    end
    $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- verilog/rv_core.sv
module rv_core import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output word_t     wb_adr,
  output word_t     wb_dat_w,
  input  word_t     wb_dat_r,
  input  logic      wb_ack,
  output logic      retire_valid,
  output word_t     retire_pc,
  output reg_addr_t retire_rd,
  output word_t     retire_data,
  output logic      halted
);

  word_t      instr, imm, rdata1, rdata2, alu_a, alu_b, alu_result, rf_wdata;
  word_t      csr_rdata, csr_wdata, mtvec, mepc, trap_pc;
  reg_addr_t  rs1, rs2, rd;
  alu_op_t    alu_op;
  csr_addr_t  csr_addr;
  logic [2:0] branch_funct;
  logic       src1_pc, src2_imm, is_branch, is_jal, is_jalr, is_load, is_store;
  logic       is_lui, is_csr, is_ecall, is_mret, is_ebreak, illegal;
  logic       zero, rf_we, csr_we, trap;

  rv_core_ctrl ctrl (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .rd, .imm, .src1_pc, .src2_imm,
    .is_branch, .is_jal, .is_jalr, .is_load, .is_store,
    .is_lui, .is_csr, .is_ecall, .is_mret, .is_ebreak,
    .branch_funct, .illegal,
    .rdata1, .rdata2,
    .result(alu_result), .zero, .alu_a, .alu_b,
    .csr_rdata, .mtvec, .mepc,
    .instr, .rf_we, .rf_wdata,
    .csr_we, .csr_wdata, .trap, .trap_pc,
    .retire_valid, .retire_pc, .retire_rd, .retire_data, .halted
  );

  rv_decoder decoder (
    .instr, .rs1, .rs2, .rd, .imm, .alu_op, .src1_pc, .src2_imm,
    .is_branch, .is_jal, .is_jalr, .is_load, .is_store,
    .is_lui, .is_csr, .is_ecall, .is_mret, .is_ebreak,
    .branch_funct, .csr_addr, .illegal
  );

  rv_alu alu (
    .a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .zero
  );

  rv_regfile regfile (
    .clk, .rs1, .rs2, .rd, .we(rf_we), .wdata(rf_wdata), .rdata1, .rdata2
  );

  // csrs steer the pc through mtvec and mepc
  rv_csr_file csr_file (
    .clk, .reset, .addr(csr_addr), .wdata(csr_wdata), .csr_we,
    .trap, .trap_pc, .rdata(csr_rdata), .mtvec, .mepc
  );

endmodule

//--- verilog/rv_core_ctrl.sv
module rv_core_ctrl import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output logic       wb_cyc,
  output logic       wb_stb,
  output logic       wb_we,
  output word_t      wb_adr,
  output word_t      wb_dat_w,
  input  word_t      wb_dat_r,
  input  logic       wb_ack,
  input  reg_addr_t  rd,
  input  word_t      imm,
  input  logic       src1_pc,
  input  logic       src2_imm,
  input  logic       is_branch,
  input  logic       is_jal,
  input  logic       is_jalr,
  input  logic       is_load,
  input  logic       is_store,
  input  logic       is_lui,
  input  logic       is_csr,
  input  logic       is_ecall,
  input  logic       is_mret,
  input  logic       is_ebreak,
  input  logic [2:0] branch_funct,
  input  logic       illegal,
  input  word_t      rdata1,
  input  word_t      rdata2,
  input  word_t      result,
  input  logic       zero,
  output word_t      alu_a,
  output word_t      alu_b,
  input  word_t      csr_rdata,
  input  word_t      mtvec,
  input  word_t      mepc,
  output word_t      instr,
  output logic       rf_we,
  output word_t      rf_wdata,
  output logic       csr_we,
  output word_t      csr_wdata,
  output logic       trap,
  output word_t      trap_pc,
  output logic       retire_valid,
  output word_t      retire_pc,
  output reg_addr_t  retire_rd,
  output word_t      retire_data,
  output logic       halted
);

  core_state_t state;
  word_t pc, pc_plus4, pc_target, pc_next;
  logic  stop, is_mem, executing, bus_done, launch, retire, writes_rd, taken;

  assign pc_plus4 = pc + 32'd4;
  assign pc_target = pc + imm;
  assign stop = is_ebreak | illegal;
  assign is_mem = is_load | is_store;
  assign executing = (state == ST_EXECUTE) && !stop;
  assign bus_done = wb_cyc & wb_ack;
  assign launch = (state == ST_FETCH || state == ST_MEMORY) && !wb_cyc;
  assign retire = (executing && !is_mem) || (state == ST_MEMORY && bus_done);
  assign writes_rd = !(is_branch | is_store | is_ecall | is_mret);

  // blt/bltu/bge/bgeu see slt result, beq/bne see the difference
  assign taken = is_branch & ((branch_funct[2] ? ~zero : zero) ^ branch_funct[0]);

  assign alu_a = src1_pc ? pc : rdata1;
  assign alu_b = src2_imm ? imm : rdata2;

  always_comb begin
    if (is_ecall)
      pc_next = mtvec;
    else if (is_mret)
      pc_next = mepc;
    else if (is_jalr)
      pc_next = {result[31:1], 1'b0};
    else if (is_jal || taken)
      pc_next = pc_target;
    else
      pc_next = pc_plus4;
  end

  always_comb begin
    if (is_load)
      rf_wdata = wb_dat_r;
    else if (is_jal || is_jalr)
      rf_wdata = pc_plus4;  // link
    else if (is_lui)
      rf_wdata = imm;
    else if (is_csr)
      rf_wdata = csr_rdata;
    else
      rf_wdata = result;
  end

  assign rf_we = retire & writes_rd;
  assign csr_we = executing & is_csr;
  assign csr_wdata = rdata1;
  assign trap = executing & is_ecall;
  assign trap_pc = pc;
  assign wb_stb = wb_cyc;
  assign halted = (state == ST_HALT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      pc <= RESET_VECTOR;
      wb_cyc <= 1'b0;
      wb_we <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= retire;
      if (launch) begin
        wb_cyc <= 1'b1;
        wb_we <= (state == ST_MEMORY) & is_store;
      end else if (bus_done) begin
        wb_cyc <= 1'b0;
        wb_we <= 1'b0;
      end
      if (retire)
        pc <= pc_next;
      case (state)
        ST_FETCH:   if (bus_done) state <= ST_EXECUTE;
        ST_EXECUTE: begin
          if (stop)
            state <= ST_HALT;
          else if (is_mem)
            state <= ST_MEMORY;
          else
            state <= ST_FETCH;
        end
        ST_MEMORY:  if (bus_done) state <= ST_FETCH;
        default:    state <= ST_HALT;  // stays until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      wb_adr <= (state == ST_MEMORY) ? result : pc;
      wb_dat_w <= rdata2;
    end
    if (state == ST_FETCH && bus_done)
      instr <= wb_dat_r;
    if (retire) begin
      retire_pc <= pc;
      retire_rd <= writes_rd ? rd : '0;
      retire_data <= (writes_rd && rd != '0) ? rf_wdata : '0;
    end
  end

endmodule

//--- verilog/rv_csr_file.sv
module rv_csr_file import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  csr_addr_t addr,
  input  word_t     wdata,
  input  logic      csr_we,
  input  logic      trap,
  input  word_t     trap_pc,
  output word_t     rdata,
  output word_t     mtvec,
  output word_t     mepc
);

  word_t mcause;
  word_t mscratch;

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
      mscratch <= '0;
    end else if (trap) begin
      mepc <= trap_pc;
      mcause <= MCAUSE_ECALL;
    end else if (csr_we) begin
      case (addr)
        CSR_MTVEC:    mtvec <= wdata;
        CSR_MEPC:     mepc <= wdata;
        CSR_MCAUSE:   mcause <= wdata;
        CSR_MSCRATCH: mscratch <= wdata;
        default: ;  // unmapped, dropped
      endcase
    end
  end

  // old value for csrrw
  always_comb begin
    case (addr)
      CSR_MTVEC:    rdata = mtvec;
      CSR_MEPC:     rdata = mepc;
      CSR_MCAUSE:   rdata = mcause;
      CSR_MSCRATCH: rdata = mscratch;
      default:      rdata = '0;
    endcase
  end

endmodule

//--- verilog/rv_regfile.sv
module rv_regfile import rv_core_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      we,
  input  word_t     wdata,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [1:31];  // x0 not stored

  always_ff @(posedge clk) begin
    if (we && rd != '0)
      regs[rd] <= wdata;
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verilog/rv_alu.sv
module rv_alu import rv_core_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result,
  output logic    zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      default:  result = '0;
    endcase
  end

  // branch compare reads this
  assign zero = (result == '0);

endmodule

//--- verilog/rv_decoder.sv
module rv_decoder import rv_core_pkg::*; (
  input  word_t      instr,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output reg_addr_t  rd,
  output word_t      imm,
  output alu_op_t    alu_op,
  output logic       src1_pc,
  output logic       src2_imm,
  output logic       is_branch,
  output logic       is_jal,
  output logic       is_jalr,
  output logic       is_load,
  output logic       is_store,
  output logic       is_lui,
  output logic       is_csr,
  output logic       is_ecall,
  output logic       is_mret,
  output logic       is_ebreak,
  output logic [2:0] branch_funct,
  output csr_addr_t  csr_addr,
  output logic       illegal
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t    arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd = instr[11:7];
  assign branch_funct = funct3;
  assign csr_addr = instr[31:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // shared by register and immediate forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    imm = imm_i;
    alu_op = ALU_ADD;
    {src1_pc, src2_imm} = 2'b00;
    {is_branch, is_jal, is_jalr, is_load, is_store} = 5'b0;
    {is_lui, is_csr, is_ecall, is_mret, is_ebreak} = 5'b0;
    illegal = 1'b0;
    case (opcode)
      OP_LUI: begin
        is_lui = 1'b1;
        imm = imm_u;
      end
      OP_AUIPC: begin
        {src1_pc, src2_imm} = 2'b11;
        imm = imm_u;
      end
      OP_JAL: begin
        is_jal = 1'b1;
        imm = imm_j;
      end
      OP_JALR: begin
        is_jalr = 1'b1;
        src2_imm = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        is_branch = 1'b1;
        imm = imm_b;
        case (funct3[2:1])
          2'b00:   alu_op = ALU_SUB;  // beq, bne on zero
          2'b10:   alu_op = ALU_SLT;
          2'b11:   alu_op = ALU_SLTU;
          default: illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        is_load = 1'b1;
        src2_imm = 1'b1;
        illegal = (funct3 != 3'b010);  // lw only
      end
      OP_STORE: begin
        is_store = 1'b1;
        src2_imm = 1'b1;
        imm = imm_s;
        illegal = (funct3 != 3'b010);
      end
      OP_IMM: begin
        src2_imm = 1'b1;
        alu_op = arith_op;
        if (funct3 == 3'b001)
          illegal = (funct7 != 7'b0000000);
        else if (funct3 == 3'b101)
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      OP_REG: begin
        alu_op = arith_op;
        if (funct7 == 7'b0100000)
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        else
          illegal = (funct7 != 7'b0000000);
      end
      OP_SYSTEM: begin
        case (instr)
          32'h0000_0073: is_ecall = 1'b1;
          32'h0010_0073: is_ebreak = 1'b1;
          32'h3020_0073: is_mret = 1'b1;
          default: begin
            is_csr = (funct3 == 3'b001);  // csrrw
            illegal = (funct3 != 3'b001);
          end
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0]  alu_op_t;

  // alu operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;  // signed less than
  localparam alu_op_t ALU_SLTU = 4'd9;  // unsigned less than

  // machine csrs
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  localparam word_t RESET_VECTOR = 32'h8000_0000;
  localparam word_t MCAUSE_ECALL = 32'd11;  // ecall from m-mode

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_MEMORY,
    ST_HALT
  } core_state_t;

endpackage
